//--- rv_decode_top.f
rtl/rv_decode_pkg.sv
rtl/rv_inst_classify.sv
rtl/rv_imm_gen.sv
rtl/rv_ctrl_gen.sv
rtl/rv_operand_fields.sv
rtl/rv_decode_top.sv
dv/rv_decode_assert.sv
dv/rv_decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := rv_decode_tb
FILELIST  := rv_decode_top.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- dv/rv_decode_tb.sv
module rv_decode_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_decode_pkg::*;

    logic         i_clk;
    logic         i_arst_n;
    inst_t        i_inst;
    xlen_t        i_pc;
    xlen_t        o_pc;
    reg_idx_t     o_rd;
    reg_idx_t     o_rs1;
    reg_idx_t     o_rs2;
    funct3_t      o_funct3;
    imm_bus_t     o_imm;
    decode_ctrl_t o_ctrl;
    logic         o_supported;

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    rv_decode_top u_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // hang guard for the whole run
    initial begin
        repeat (5000) @(posedge i_clk);
        $display("timeout: the test sequence did not finish in 5000 cycles");
        $display("Simulation failed");
        $finish;
    end

    function automatic inst_t encode_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                          funct3_t f3, reg_idx_t rd, opcode_t opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    // expected alu bundle for OP and OP_IMM
    function automatic alu_ctrl_t expect_alu(funct3_t f3, logic imm, logic alt);
        alu_ctrl_t a;
        a = '0;
        a.arith_add          = (f3 == 3'b000) & ~alt;
        a.arith_sub          = (f3 == 3'b000) & alt;
        a.arith_shl          = (f3 == 3'b001);
        a.cmp_lts            = (f3 == 3'b010);
        a.cmp_ltu            = (f3 == 3'b011);
        a.bits_xor           = (f3 == 3'b100);
        a.arith_shr          = (f3 == 3'b101);
        a.shift_arithmetical = (f3 == 3'b101) & alt;
        a.bits_or            = (f3 == 3'b110);
        a.bits_and           = (f3 == 3'b111);
        a.res_cmp            = a.cmp_lts | a.cmp_ltu;
        a.res_bits           = a.bits_xor | a.bits_or | a.bits_and;
        a.res_arith          = a.arith_shl | a.arith_shr | a.arith_sub | (a.arith_add & ~imm);
        return a;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0d ns %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-10s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "bad",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic drive(inst_t w, xlen_t pc);
        @(posedge i_clk);
        i_inst <= w;
        i_pc   <= pc;
        #1;
    endtask

    // flags are {jal, jalr, branch, store}
    task automatic check_flow(inst_t w, logic rw, op1_src_t o1, op2_src_t o2, res_src_t rs,
                              logic [3:0] flags, alu_ctrl_t alu);
        decode_ctrl_t e;
        e = {rw, o1, o2, rs, alu, flags};
        drive(w, i_pc);
        check_val("o_ctrl", 32'(o_ctrl), 32'(e));
    endtask

    task automatic test_pc();
        xlen_t prev;
        xlen_t pc;
        #1;
        check_val("o_pc", o_pc, '0);
        @(posedge i_clk);
        i_arst_n <= 1'b1;
        prev = i_pc;
        for (int n = 0; n < 20; n++) begin
            pc = $urandom;
            drive($urandom, pc);
            check_val("o_pc", o_pc, prev);    // one edge behind
            prev = pc;
        end
        end_test("pc");
    endtask

    task automatic test_imm();
        inst_t w;
        for (int n = 0; n < 50; n++) begin
            w = $urandom;
            drive(w, i_pc);
            check_val("imm_i", o_imm.imm_i, 32'($signed(w) >>> 20));
            check_val("imm_s", o_imm.imm_s, 32'($signed({w[31:25], w[11:7]})));
            check_val("imm_b", o_imm.imm_b,
                      32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0})));
            check_val("imm_u", o_imm.imm_u, w & 32'hffff_f000);
            check_val("imm_j", o_imm.imm_j,
                      32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0})));
        end
        end_test("imm");
    endtask

    task automatic test_fields();
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        funct3_t  f3;
        for (int n = 0; n < 10; n++) begin
            rd  = reg_idx_t'($urandom);
            rs1 = reg_idx_t'($urandom);
            rs2 = reg_idx_t'($urandom);
            f3  = funct3_t'($urandom);
            drive(encode_word(FUNCT7_BASE, rs2, rs1, f3, rd, OPC_OP), i_pc);
            check_val("o_rd", 32'(o_rd), 32'(rd));
            check_val("o_rs1", 32'(o_rs1), 32'(rs1));
            check_val("o_rs2", 32'(o_rs2), 32'(rs2));
            check_val("o_funct3", 32'(o_funct3), 32'(f3));
        end
        rs1 = reg_idx_t'($urandom_range(31, 1));
        drive(encode_word(7'h55, rs2, rs1, f3, rd, OPC_LUI), i_pc);
        check_val("o_rs1", 32'(o_rs1), '0);
        end_test("fields");
    endtask

    task automatic test_alu();
        logic [6:0] f7;
        inst_t      w;
        for (int imm = 0; imm < 2; imm++) begin
            for (int f = 0; f < 8; f++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    // alt form only for sub, sra and srai
                    if (alt == 1 && !(f == 5 || (f == 0 && imm == 0))) continue;
                    f7 = (alt == 1) ? FUNCT7_ALT : FUNCT7_BASE;
                    w  = encode_word(f7, reg_idx_t'($urandom), reg_idx_t'($urandom),
                                     funct3_t'(f), reg_idx_t'($urandom),
                                     (imm == 1) ? OPC_OP_IMM : OPC_OP);
                    check_flow(w, 1'b1, 2'b01, (imm == 1) ? 5'b10000 : 5'b00001, 3'b001,
                               4'b0000, expect_alu(funct3_t'(f), imm == 1, alt == 1));
                end
            end
        end
        end_test("alu");
    endtask

    task automatic test_flow();
        alu_ctrl_t a;
        funct3_t   f3;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            f3             = funct3_t'(f);
            a              = '0;
            a.res_cmp      = 1'b1;
            a.cmp_eq       = ~f3[2];
            a.cmp_lts      = f3[2] & ~f3[1];
            a.cmp_ltu      = f3[2] & f3[1];
            a.cmp_inversed = f3[0];
            check_flow(encode_word(7'h2a, 5'd3, 5'd4, f3, 5'd9, OPC_BRANCH),
                       1'b0, 2'b01, 5'b00001, 3'b001, 4'b0010, a);
        end
        a = '0;
        check_flow(encode_word(7'h11, 5'd2, 5'd3, 3'b000, 5'd1, OPC_JAL),
                   1'b1, 2'b10, 5'b01000, 3'b010, 4'b1000, a);
        check_flow(encode_word(7'h00, 5'd8, 5'd5, 3'b000, 5'd1, OPC_JALR),
                   1'b1, 2'b01, 5'b10000, 3'b010, 4'b0100, a);
        check_flow(encode_word(7'h01, 5'd4, 5'd2, 3'b010, 5'd6, OPC_LOAD),
                   1'b1, 2'b01, 5'b10000, 3'b100, 4'b0000, a);
        check_flow(encode_word(7'h01, 5'd7, 5'd2, 3'b010, 5'd4, OPC_STORE),
                   1'b0, 2'b01, 5'b00100, 3'b001, 4'b0001, a);
        end_test("flow");
    endtask

    task automatic check_sup(inst_t w, logic exp);
        drive(w, i_pc);
        check_val("o_supported", 32'(o_supported), 32'(exp));
    endtask

    task automatic test_supported();
        check_sup('0, 1'b1);
        check_sup(encode_word(FUNCT7_BASE, 5'd0, 5'd1, 3'b010, 5'd2, OPC_LOAD), 1'b1);
        check_sup(encode_word(7'h12, 5'd3, 5'd1, 3'b000, 5'd2, OPC_OP_IMM), 1'b1);
        check_sup(encode_word(FUNCT7_ALT, 5'd3, 5'd1, 3'b101, 5'd2, OPC_OP_IMM), 1'b1);
        check_sup(encode_word(7'h3c, 5'd9, 5'd7, 3'b110, 5'd2, OPC_AUIPC), 1'b1);
        check_sup(encode_word(7'h3c, 5'd9, 5'd7, 3'b011, 5'd2, OPC_LUI), 1'b1);
        check_sup(encode_word(7'h01, 5'd2, 5'd1, 3'b010, 5'd4, OPC_STORE), 1'b1);
        check_sup(encode_word(FUNCT7_BASE, 5'd2, 5'd1, 3'b111, 5'd3, OPC_OP), 1'b1);
        check_sup(encode_word(FUNCT7_ALT, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 1'b1);
        check_sup(encode_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd8, OPC_BRANCH), 1'b1);
        check_sup(encode_word(7'h00, 5'd0, 5'd1, 3'b000, 5'd1, OPC_JALR), 1'b1);
        check_sup(encode_word(7'h40, 5'd5, 5'd9, 3'b100, 5'd1, OPC_JAL), 1'b1);
        check_sup(encode_word(7'h08, 5'd15, 5'd0, 3'b000, 5'd0, OPC_MISC_MEM), 1'b1);
        check_sup(32'h0000_0073, 1'b0);     // ecall
        check_sup(encode_word(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 1'b0);
        check_sup(encode_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd8, OPC_BRANCH), 1'b0);
        check_sup(32'h00a5_0511, 1'b0);     // addi pattern with low bits 01
        end_test("supported");
    endtask

    initial begin
        void'($urandom(32'h368e8901));
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        i_arst_n     = 1'b0;
        i_inst       = '0;
        i_pc         = 32'h0000_1000;
        repeat (2) @(posedge i_clk);
        test_pc();
        test_imm();
        test_fields();
        test_alu();
        test_flow();
        test_supported();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- dv/rv_decode_assert.sv
module rv_decode_assert (
    input logic                        i_clk,
    input logic                        i_arst_n,
    input rv_decode_pkg::decode_ctrl_t i_ctrl
);
    timeunit 1ns;
    timeprecision 1ps;

    op2_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot(i_ctrl.op2_src)) else $error("op2_src not one-hot %b", i_ctrl.op2_src);

    res_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot(i_ctrl.res_src)) else $error("res_src not one-hot %b", i_ctrl.res_src);

    // at most one alu result group
    alu_group: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_ctrl.alu_ctrl.res_cmp, i_ctrl.alu_ctrl.res_bits, i_ctrl.alu_ctrl.res_arith}))
        else $error("more than one alu result group set");

endmodule

bind rv_decode_top rv_decode_assert u_assert (.i_clk(i_clk), .i_arst_n(i_arst_n), .i_ctrl(o_ctrl));

//--- rtl/rv_decode_top.sv
module rv_decode_top (
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  rv_decode_pkg::inst_t         i_inst,
    input  rv_decode_pkg::xlen_t         i_pc,
    output rv_decode_pkg::xlen_t         o_pc,
    output rv_decode_pkg::reg_idx_t      o_rd,
    output rv_decode_pkg::reg_idx_t      o_rs1,
    output rv_decode_pkg::reg_idx_t      o_rs2,
    output rv_decode_pkg::funct3_t       o_funct3,
    output rv_decode_pkg::imm_bus_t      o_imm,
    output rv_decode_pkg::decode_ctrl_t  o_ctrl,
    output logic                         o_supported
);
    import rv_decode_pkg::*;

    inst_class_t inst_class;

    rv_inst_classify u_classify (
        .i_inst      (i_inst),
        .o_class     (inst_class),
        .o_supported (o_supported)
    );

    rv_imm_gen u_imm (
        .i_inst (i_inst),
        .o_imm  (o_imm)
    );

    rv_ctrl_gen u_ctrl (
        .i_class  (inst_class),
        .i_funct3 (o_funct3),   // funct3 comes from the field slicer
        .o_ctrl   (o_ctrl)
    );

    rv_operand_fields u_fields (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_inst   (i_inst),
        .i_pc     (i_pc),
        .i_class  (inst_class),
        .o_rd     (o_rd),
        .o_rs1    (o_rs1),
        .o_rs2    (o_rs2),
        .o_funct3 (o_funct3),
        .o_pc     (o_pc)
    );

endmodule

//--- rtl/rv_operand_fields.sv
module rv_operand_fields (
    input  logic                       i_clk,
    input  logic                       i_arst_n,
    input  rv_decode_pkg::inst_t       i_inst,
    input  rv_decode_pkg::xlen_t       i_pc,
    input  rv_decode_pkg::inst_class_t i_class,
    output rv_decode_pkg::reg_idx_t    o_rd,
    output rv_decode_pkg::reg_idx_t    o_rs1,
    output rv_decode_pkg::reg_idx_t    o_rs2,
    output rv_decode_pkg::funct3_t     o_funct3,
    output rv_decode_pkg::xlen_t       o_pc
);

    assign o_rd  = i_inst[11:7];
    assign o_rs2 = i_inst[24:20];

    // lui adds its immediate to x0
    assign o_rs1 = i_class.lui ? '0 : i_inst[19:15];

    assign o_funct3 = i_inst[14:12];

    // pc lines up with the next stage
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= '0;
        end else begin
            o_pc <= i_pc;
        end
    end

endmodule

//--- rtl/rv_ctrl_gen.sv
module rv_ctrl_gen (
    input  rv_decode_pkg::inst_class_t  i_class,
    input  rv_decode_pkg::funct3_t      i_funct3,
    output rv_decode_pkg::decode_ctrl_t o_ctrl
);

    logic [7:0] f3;
    logic       reg_b;     // op with base funct7
    logic       reg_a;     // op with alt funct7
    logic       imm;
    logic       br;

    assign f3    = 8'b1 << i_funct3;
    assign reg_b = i_class.op_reg & i_class.f7_base;
    assign reg_a = i_class.op_reg & i_class.f7_alt;
    assign imm   = i_class.op_imm;
    assign br    = i_class.branch;

    logic op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and;
    logic op_addi, op_slli, op_slti, op_sltiu, op_xori, op_srli, op_srai, op_ori, op_andi;

    assign op_add   = reg_b & f3[0];
    assign op_sub   = reg_a & f3[0];
    assign op_sll   = reg_b & f3[1];
    assign op_slt   = reg_b & f3[2];
    assign op_sltu  = reg_b & f3[3];
    assign op_xor   = reg_b & f3[4];
    assign op_srl   = reg_b & f3[5];
    assign op_sra   = reg_a & f3[5];
    assign op_or    = reg_b & f3[6];
    assign op_and   = reg_b & f3[7];

    assign op_addi  = imm & f3[0];
    assign op_slli  = imm & f3[1];
    assign op_slti  = imm & f3[2];
    assign op_sltiu = imm & f3[3];
    assign op_xori  = imm & f3[4];
    assign op_srli  = imm & f3[5] & i_class.f7_base;
    assign op_srai  = imm & f3[5] & i_class.f7_alt;
    assign op_ori   = imm & f3[6];
    assign op_andi  = imm & f3[7];

    assign o_ctrl.reg_write = i_class.load | imm | i_class.auipc | i_class.op_reg |
                              i_class.lui | i_class.jalr | i_class.jal;

    assign o_ctrl.op1_src.pc = i_class.auipc | i_class.jal;
    assign o_ctrl.op1_src.r  = ~(i_class.auipc | i_class.jal);

    assign o_ctrl.op2_src.j = i_class.jal;
    assign o_ctrl.op2_src.u = i_class.lui | i_class.auipc;
    assign o_ctrl.op2_src.i = i_class.jalr | i_class.load | imm;
    assign o_ctrl.op2_src.s = i_class.store;
    assign o_ctrl.op2_src.r = ~(i_class.jal | i_class.lui | i_class.auipc | i_class.jalr |
                                i_class.load | imm | i_class.store);

    assign o_ctrl.res_src.memory = i_class.load;
    assign o_ctrl.res_src.pc_p4  = i_class.jal | i_class.jalr;
    assign o_ctrl.res_src.alu    = ~(i_class.load | i_class.jal | i_class.jalr);

    // branches use funct3[0] to invert the compare
    assign o_ctrl.alu_ctrl.cmp_eq       = br & (f3[0] | f3[1]);
    assign o_ctrl.alu_ctrl.cmp_lts      = op_slt | op_slti | (br & (f3[4] | f3[5]));
    assign o_ctrl.alu_ctrl.cmp_ltu      = op_sltu | op_sltiu | (br & (f3[6] | f3[7]));
    assign o_ctrl.alu_ctrl.cmp_inversed = br & i_funct3[0];
    assign o_ctrl.alu_ctrl.res_cmp      = br | op_slt | op_slti | op_sltu | op_sltiu;

    assign o_ctrl.alu_ctrl.bits_and = op_and | op_andi;
    assign o_ctrl.alu_ctrl.bits_or  = op_or | op_ori;
    assign o_ctrl.alu_ctrl.bits_xor = op_xor | op_xori;
    assign o_ctrl.alu_ctrl.res_bits = op_and | op_andi | op_or | op_ori | op_xor | op_xori;

    assign o_ctrl.alu_ctrl.arith_shl          = op_sll | op_slli;
    assign o_ctrl.alu_ctrl.arith_shr          = op_srl | op_srli | op_sra | op_srai;
    assign o_ctrl.alu_ctrl.shift_arithmetical = op_sra | op_srai;
    assign o_ctrl.alu_ctrl.arith_sub          = op_sub;
    assign o_ctrl.alu_ctrl.arith_add          = op_add | op_addi;
    // addi stays out of the group so the alu falls back to add
    assign o_ctrl.alu_ctrl.res_arith = op_sll | op_slli | op_srl | op_srli |
                                       op_sra | op_srai | op_sub | op_add;

    assign o_ctrl.inst_jal    = i_class.jal;
    assign o_ctrl.inst_jalr   = i_class.jalr;
    assign o_ctrl.inst_branch = br;
    assign o_ctrl.inst_store  = i_class.store;

endmodule

//--- rtl/rv_imm_gen.sv
module rv_imm_gen (
    input  rv_decode_pkg::inst_t    i_inst,
    output rv_decode_pkg::imm_bus_t o_imm
);

    logic sign;

    assign sign = i_inst[31];

    assign o_imm.imm_i = {{21{sign}}, i_inst[30:20]};
    assign o_imm.imm_s = {{21{sign}}, i_inst[30:25], i_inst[11:7]};

    // halfword aligned branch offset
    assign o_imm.imm_b = {
        {20{sign}},
        i_inst[7],
        i_inst[30:25],
        i_inst[11:8],
        1'b0
    };

    assign o_imm.imm_u = {i_inst[31:12], 12'b0};

    assign o_imm.imm_j = {
        {12{sign}},
        i_inst[19:12],
        i_inst[20],
        i_inst[30:21],
        1'b0            // jal target is halfword aligned
    };

endmodule

//--- rtl/rv_inst_classify.sv
module rv_inst_classify (
    input  rv_decode_pkg::inst_t       i_inst,
    output rv_decode_pkg::inst_class_t o_class,
    output logic                       o_supported
);
    import rv_decode_pkg::*;

    opcode_t    opcode;
    funct3_t    funct3;
    logic       full;
    logic [7:0] f3;     // funct3 as one-hot

    logic sup_load;
    logic sup_op_imm;
    logic sup_store;
    logic sup_op;
    logic sup_branch;
    logic sup_jalr;
    logic sup_misc;

    assign opcode = i_inst[6:2];
    assign funct3 = i_inst[14:12];
    assign full   = (i_inst[1:0] == INST_LEN_32);
    assign f3     = 8'b1 << funct3;

    // opcode groups
    assign o_class.load     = full & (opcode == OPC_LOAD);
    assign o_class.store    = full & (opcode == OPC_STORE);
    assign o_class.op_imm   = full & (opcode == OPC_OP_IMM);
    assign o_class.op_reg   = full & (opcode == OPC_OP);
    assign o_class.branch   = full & (opcode == OPC_BRANCH);
    assign o_class.lui      = full & (opcode == OPC_LUI);
    assign o_class.auipc    = full & (opcode == OPC_AUIPC);
    assign o_class.jal      = full & (opcode == OPC_JAL);
    assign o_class.jalr     = full & (opcode == OPC_JALR);
    assign o_class.misc_mem = full & (opcode == OPC_MISC_MEM);

    assign o_class.is_nop  = ~|i_inst;
    assign o_class.f7_base = (i_inst[31:25] == FUNCT7_BASE);
    assign o_class.f7_alt  = (i_inst[31:25] == FUNCT7_ALT);

    // lb lh lw lbu lhu
    assign sup_load   = o_class.load & (|f3[2:0] | f3[4] | f3[5]);
    // shift right needs a known funct7
    assign sup_op_imm = o_class.op_imm & (~f3[5] | o_class.f7_base | o_class.f7_alt);
    assign sup_store  = o_class.store & (|f3[2:0]);
    assign sup_op     = o_class.op_reg &
                        (o_class.f7_base | (o_class.f7_alt & (f3[0] | f3[5])));
    assign sup_branch = o_class.branch & ~(f3[2] | f3[3]);
    assign sup_jalr   = o_class.jalr & f3[0];
    assign sup_misc   = o_class.misc_mem & (f3[0] | f3[1]);   // fence, fence.i

    // system opcode falls through as unsupported
    assign o_supported = o_class.is_nop |
                         sup_load       |
                         sup_op_imm     |
                         o_class.auipc  |
                         o_class.lui    |
                         sup_store      |
                         sup_op         |
                         sup_branch     |
                         sup_jalr       |
                         o_class.jal    |
                         sup_misc;

endmodule

//--- rtl/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  opcode_t;   // inst[6:2]

    // major opcodes
    localparam opcode_t OPC_LOAD     = 5'b00000;
    localparam opcode_t OPC_MISC_MEM = 5'b00011;   // fence, fence.i
    localparam opcode_t OPC_OP_IMM   = 5'b00100;
    localparam opcode_t OPC_AUIPC    = 5'b00101;
    localparam opcode_t OPC_STORE    = 5'b01000;
    localparam opcode_t OPC_OP       = 5'b01100;
    localparam opcode_t OPC_LUI      = 5'b01101;
    localparam opcode_t OPC_BRANCH   = 5'b11000;
    localparam opcode_t OPC_JALR     = 5'b11001;
    localparam opcode_t OPC_JAL      = 5'b11011;

    localparam logic [1:0] INST_LEN_32 = 2'b11;     // low bits of a non-compressed word
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    typedef struct packed {
        logic load;
        logic store;
        logic op_imm;
        logic op_reg;
        logic branch;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic misc_mem;
        logic is_nop;      // all-zero word
        logic f7_base;
        logic f7_alt;
    } inst_class_t;

    typedef struct packed {
        xlen_t imm_i;
        xlen_t imm_s;
        xlen_t imm_b;
        xlen_t imm_u;
        xlen_t imm_j;
    } imm_bus_t;

    // one-hot source selects
    typedef struct packed {
        logic pc;
        logic r;
    } op1_src_t;

    typedef struct packed {
        logic i;
        logic j;
        logic s;
        logic u;
        logic r;
    } op2_src_t;

    typedef struct packed {
        logic memory;
        logic pc_p4;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic res_cmp;
        logic res_bits;
        logic res_arith;
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_shl;
        logic arith_shr;
        logic arith_sub;
        logic arith_add;
        logic shift_arithmetical;
    } alu_ctrl_t;

    typedef struct packed {
        logic      reg_write;
        op1_src_t  op1_src;
        op2_src_t  op2_src;
        res_src_t  res_src;
        alu_ctrl_t alu_ctrl;
        logic      inst_jal;
        logic      inst_jalr;
        logic      inst_branch;
        logic      inst_store;
    } decode_ctrl_t;

endpackage
